/* source/char_pkg.sv */
// shared definitions for the player character
// field geometry, physics constants, coordinate / state / facing types
// jump factor and launch speed helpers
package char_pkg;

    //------------------------------------------------------------
    // types
    //------------------------------------------------------------
    typedef logic signed [16:0] phy_t;      // coordinate, velocity, position
    typedef logic signed [1:0]  face_t;     // +1 left, -1 right
    typedef logic [15:0]        charge_t;   // jump charge count

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        WALK_LEFT  = 3'd1,
        WALK_RIGHT = 3'd2,
        CHARGE     = 3'd3,
        JUMP       = 3'd4,
        BOUNCE     = 3'd5
    } move_state_t;

    localparam face_t FACE_LEFT  = 2'sb01;
    localparam face_t FACE_RIGHT = 2'sb11;

    //------------------------------------------------------------
    // field geometry
    //------------------------------------------------------------
    localparam int   SMOOTH_FACTOR = 9;     // fraction bits of a velocity
    localparam phy_t MIN_POS_X     = 17'sd160;
    localparam phy_t MAX_POS_X     = 17'sd518;
    localparam phy_t FLOOR_Y       = 17'sd20;

    //------------------------------------------------------------
    // physics
    //------------------------------------------------------------
    localparam phy_t WALK_STEP  = 17'sd3;
    localparam phy_t GRAVITY    = -17'sd512;    // per airborne step
    localparam phy_t MAX_VEL    = 17'sd29696;
    localparam phy_t JUMP_VEL_X = 17'sd1024;
    localparam phy_t JUMP_VEL_Y = 17'sd3072;

    localparam charge_t CHARGE_START = 16'd1;
    localparam charge_t CHARGE_STEP  = 16'd10;
    localparam charge_t MAX_CHARGE   = 16'd500;  // forces the jump

    // charge scaled up into velocity units
    function automatic phy_t jump_factor(input charge_t charge);
        phy_t cnt;
        cnt = phy_t'({1'b0, charge});
        return cnt << 3;
    endfunction

    // unsigned horizontal launch speed, base plus 3/8 of the factor
    function automatic phy_t launch_vel_x(input charge_t charge);
        phy_t jf;
        jf = jump_factor(charge);
        return JUMP_VEL_X + (jf >>> 2) + (jf >>> 3);
    endfunction

endpackage

/* source/input_sync.sv */
// button and step strobe registers
// jump press edge detect
`timescale 1ns/1ps

module input_sync (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic step,
    input  logic left_btn,
    input  logic right_btn,
    input  logic jump_btn,
    output logic step_d,
    output logic left_held,
    output logic right_held,
    output logic jump_held,
    output logic jump_press
);

    // one register stage on every input
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            step_d     <= 1'b0;
            left_held  <= 1'b0;
            right_held <= 1'b0;
            jump_held  <= 1'b0;
        end else begin
            step_d     <= step;
            left_held  <= left_btn;
            right_held <= right_btn;
            jump_held  <= jump_btn;
        end
    end

    // rising edge, raw level high while the registered copy is still low
    assign jump_press = jump_btn & ~jump_held;

endmodule

/* source/move_fsm.sv */
// movement state machine
// jump armed flag, charge counter and facing register
`timescale 1ns/1ps

module move_fsm (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 step_d,
    input  logic                 left_held,
    input  logic                 right_held,
    input  logic                 jump_held,
    input  logic                 jump_press,
    input  logic                 on_ground,
    input  logic                 side_hit,
    output char_pkg::move_state_t state,
    output char_pkg::face_t      face,
    output char_pkg::charge_t    charge
);

    char_pkg::move_state_t next_state;
    logic                  jump_armed;
    logic                  charge_full;
    logic                  enter_bounce;

    assign charge_full  = (charge >= char_pkg::MAX_CHARGE);
    assign enter_bounce = side_hit && (state != char_pkg::BOUNCE);

    //------------------------------------------------------------
    // next state
    //------------------------------------------------------------
    always_comb begin
        next_state = char_pkg::IDLE;
        if (enter_bounce) begin
            next_state = char_pkg::BOUNCE;      // wall hit in the air
        end else begin
            case (state)
                char_pkg::IDLE, char_pkg::WALK_LEFT, char_pkg::WALK_RIGHT: begin
                    if (!on_ground) begin
                        next_state = char_pkg::IDLE;
                    end else if (left_held) begin
                        next_state = char_pkg::WALK_LEFT;
                    end else if (right_held) begin
                        next_state = char_pkg::WALK_RIGHT;
                    end else if (jump_armed) begin
                        next_state = char_pkg::CHARGE;
                    end else begin
                        next_state = char_pkg::IDLE;
                    end
                end
                char_pkg::CHARGE: begin
                    if (!jump_held || charge_full) begin
                        next_state = char_pkg::JUMP;   // release or full charge
                    end else begin
                        next_state = char_pkg::CHARGE;
                    end
                end
                default: begin
                    next_state = char_pkg::IDLE;    // JUMP and BOUNCE last one step
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= char_pkg::IDLE;
        end else if (step_d) begin
            state <= next_state;
        end
    end

    //------------------------------------------------------------
    // jump arming, follows the press edge on every clock
    //------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_armed <= 1'b0;
        end else if (jump_press && on_ground) begin
            jump_armed <= 1'b1;
        end else if (state == char_pkg::JUMP) begin
            jump_armed <= 1'b0;
        end
    end

    // charge counter
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            charge <= char_pkg::CHARGE_START;
        end else if (step_d) begin
            if (state == char_pkg::CHARGE) begin
                charge <= charge + char_pkg::CHARGE_STEP;
            end else if (state == char_pkg::JUMP) begin
                charge <= char_pkg::CHARGE_START;   // ready for the next jump
            end
        end
    end

    // facing
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            face <= char_pkg::FACE_LEFT;
        end else if (step_d) begin
            if (enter_bounce) begin
                face <= -face;                      // turn around off the wall
            end else if (state == char_pkg::WALK_LEFT) begin
                face <= char_pkg::FACE_LEFT;
            end else if (state == char_pkg::WALK_RIGHT) begin
                face <= char_pkg::FACE_RIGHT;
            end
        end
    end

endmodule

/* source/motion_integrator.sv */
// velocity and position integration for one game step
// gravity, jump launch, bounce damping, speed limit, wall and floor clamp
`timescale 1ns/1ps

module motion_integrator #(
    parameter int INIT_POS_X = 328,
    parameter int INIT_POS_Y = 20
) (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  step_d,
    input  char_pkg::move_state_t state,
    input  char_pkg::face_t       face,
    input  char_pkg::charge_t     charge,
    input  logic                  on_ground,
    output char_pkg::phy_t        pos_x,
    output char_pkg::phy_t        pos_y,
    output char_pkg::phy_t        vel_x,
    output char_pkg::phy_t        vel_y
);

    char_pkg::phy_t vel_inc;
    char_pkg::phy_t launch_x;
    char_pkg::phy_t vel_x_raw, vel_y_raw;
    char_pkg::phy_t vel_x_sat, vel_y_sat;
    char_pkg::phy_t walk_dx;
    char_pkg::phy_t pos_x_sum, pos_y_sum;
    char_pkg::phy_t pos_x_nxt, pos_y_nxt;
    char_pkg::phy_t vel_x_nxt, vel_y_nxt;

    function automatic char_pkg::phy_t sat_vel(input char_pkg::phy_t v);
        if (v > char_pkg::MAX_VEL) begin
            return char_pkg::MAX_VEL;
        end else if (v < -char_pkg::MAX_VEL) begin
            return -char_pkg::MAX_VEL;
        end
        return v;
    endfunction

    //------------------------------------------------------------
    // velocity
    //------------------------------------------------------------
    always_comb begin
        vel_inc  = (!on_ground && state != char_pkg::JUMP) ? char_pkg::GRAVITY : '0;
        launch_x = char_pkg::launch_vel_x(charge);

        case (state)
            char_pkg::JUMP: begin
                vel_x_raw = face[1] ? -launch_x : launch_x;   // toward the facing
                vel_y_raw = char_pkg::JUMP_VEL_Y + char_pkg::jump_factor(charge);
            end
            char_pkg::BOUNCE: begin
                // reflect, ends near -3/4 of the old speed
                vel_x_raw = vel_x - (vel_x + (vel_x >>> 1) + (vel_x >>> 2));
                vel_y_raw = vel_y + vel_inc;
            end
            default: begin
                vel_x_raw = vel_x;
                vel_y_raw = vel_y + vel_inc;
            end
        endcase

        vel_x_sat = sat_vel(vel_x_raw);
        vel_y_sat = sat_vel(vel_y_raw);
    end

    //------------------------------------------------------------
    // position and clamping
    //------------------------------------------------------------
    always_comb begin
        case (state)
            char_pkg::WALK_LEFT:  walk_dx = char_pkg::WALK_STEP;
            char_pkg::WALK_RIGHT: walk_dx = -char_pkg::WALK_STEP;
            default:              walk_dx = '0;
        endcase

        pos_x_sum = pos_x + walk_dx + (vel_x_sat >>> char_pkg::SMOOTH_FACTOR);
        pos_y_sum = pos_y + (vel_y_sat >>> char_pkg::SMOOTH_FACTOR);

        if (pos_x_sum < char_pkg::MIN_POS_X) begin
            pos_x_nxt = char_pkg::MIN_POS_X;
        end else if (pos_x_sum > char_pkg::MAX_POS_X) begin
            pos_x_nxt = char_pkg::MAX_POS_X;
        end else begin
            pos_x_nxt = pos_x_sum;
        end

        // landing stops all motion
        if (pos_y_sum < char_pkg::FLOOR_Y) begin
            pos_y_nxt = char_pkg::FLOOR_Y;
            vel_x_nxt = '0;
            vel_y_nxt = '0;
        end else begin
            pos_y_nxt = pos_y_sum;
            vel_x_nxt = vel_x_sat;
            vel_y_nxt = vel_y_sat;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pos_x <= char_pkg::phy_t'(INIT_POS_X);
            pos_y <= char_pkg::phy_t'(INIT_POS_Y);
            vel_x <= '0;
            vel_y <= '0;
        end else if (step_d) begin
            pos_x <= pos_x_nxt;
            pos_y <= pos_y_nxt;
            vel_x <= vel_x_nxt;
            vel_y <= vel_y_nxt;
        end
    end

endmodule

/* source/contact_detect.sv */
// floor and side wall contact flags
`timescale 1ns/1ps

module contact_detect (
    input  logic           sys_clk,
    input  logic           sys_rst_n,
    input  char_pkg::phy_t pos_x,
    input  char_pkg::phy_t pos_y,
    output logic           on_ground,
    output logic           side_hit
);

    logic at_floor;
    logic at_side;
    logic airborne;

    assign at_floor = (pos_y == char_pkg::FLOOR_Y);
    assign airborne = (pos_y > char_pkg::FLOOR_Y);

    // x is clamped, so either limit means a wall
    assign at_side = (pos_x <= char_pkg::MIN_POS_X) || (pos_x >= char_pkg::MAX_POS_X);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            on_ground <= 1'b0;
            side_hit  <= 1'b0;
        end else begin
            on_ground <= at_floor;
            side_hit  <= at_side && airborne;   // walking into a wall is no hit
        end
    end

endmodule

/* source/char_top.sv */
// player character top level
// input registers, movement FSM, integrator and contact detection
`timescale 1ns/1ps

module char_top #(
    parameter int INIT_POS_X = 328,
    parameter int INIT_POS_Y = 20
) (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  step,
    input  logic                  left_btn,
    input  logic                  right_btn,
    input  logic                  jump_btn,
    output char_pkg::phy_t        pos_x,
    output char_pkg::phy_t        pos_y,
    output char_pkg::phy_t        vel_x,
    output char_pkg::phy_t        vel_y,
    output char_pkg::move_state_t state,
    output char_pkg::face_t       face,
    output logic                  on_ground
);

    logic              step_d;
    logic              left_held;
    logic              right_held;
    logic              jump_held;
    logic              jump_press;
    logic              side_hit;
    char_pkg::charge_t charge;

    input_sync input_sync_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .step       (step),
        .left_btn   (left_btn),
        .right_btn  (right_btn),
        .jump_btn   (jump_btn),
        .step_d     (step_d),
        .left_held  (left_held),
        .right_held (right_held),
        .jump_held  (jump_held),
        .jump_press (jump_press)
    );

    move_fsm move_fsm_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .step_d     (step_d),
        .left_held  (left_held),
        .right_held (right_held),
        .jump_held  (jump_held),
        .jump_press (jump_press),
        .on_ground  (on_ground),
        .side_hit   (side_hit),
        .state      (state),
        .face       (face),
        .charge     (charge)
    );

    motion_integrator #(
        .INIT_POS_X (INIT_POS_X),
        .INIT_POS_Y (INIT_POS_Y)
    ) motion_integrator_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .step_d     (step_d),
        .state      (state),
        .face       (face),
        .charge     (charge),
        .on_ground  (on_ground),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .vel_x      (vel_x),
        .vel_y      (vel_y)
    );

    contact_detect contact_detect_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .on_ground  (on_ground),
        .side_hit   (side_hit)
    );

endmodule

/* dv/char_chk.sv */
// movement and velocity assertions bound into the FSM and integrator
`timescale 1ns/1ps

module char_chk #(
    parameter bit VEL_CHECK = 1'b0    // set in the integrator copy
) (
    input logic                  sys_clk,
    input logic                  sys_rst_n,
    input logic                  step_d,
    input char_pkg::move_state_t state,
    input char_pkg::phy_t        vel_x,
    input char_pkg::phy_t        vel_y
);

    if (VEL_CHECK) begin : g_vel
        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            (vel_x <= char_pkg::MAX_VEL) && (vel_x >= -char_pkg::MAX_VEL) &&
            (vel_y <= char_pkg::MAX_VEL) && (vel_y >= -char_pkg::MAX_VEL))
            else $error("velocity beyond the speed limit");
    end else begin : g_state
        // charge ends only in a jump or a wall bounce
        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            (state == char_pkg::CHARGE && step_d) |=>
                state inside {char_pkg::CHARGE, char_pkg::JUMP, char_pkg::BOUNCE})
            else $error("state left CHARGE toward %0d", state);

        assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            (state == char_pkg::JUMP && step_d) |=> state != char_pkg::JUMP)
            else $error("JUMP lasted more than one step");
    end

endmodule

bind move_fsm char_chk #(.VEL_CHECK (1'b0)) fsm_chk_i (
    .sys_clk (sys_clk), .sys_rst_n (sys_rst_n), .step_d (step_d),
    .state (state), .vel_x ('0), .vel_y ('0)
);

bind motion_integrator char_chk #(.VEL_CHECK (1'b1)) vel_chk_i (
    .sys_clk (sys_clk), .sys_rst_n (sys_rst_n), .step_d (step_d),
    .state (state), .vel_x (vel_x), .vel_y (vel_y)
);

/* dv/char_tests.svh */
// step rule model and directed tests
`ifndef CHAR_TESTS_SVH
`define CHAR_TESTS_SVH

int                    m_px = 328;
int                    m_py = 20;
int                    m_vx = 0;
int                    m_vy = 0;
int                    m_face = 1;
int                    m_charge = 1;
char_pkg::move_state_t m_state = char_pkg::IDLE;
logic                  m_ground = 1'b0;
logic                  m_side = 1'b0;
logic                  m_armed = 1'b0;

function automatic int limit_vel(input int v);
    int lim;
    lim = int'(char_pkg::MAX_VEL);
    if (v > lim) return lim;
    if (v < -lim) return -lim;
    return v;
endfunction

//------------------------------------------------------------
// model of one step from the game rules
//------------------------------------------------------------
task automatic model_step(input logic l, input logic r, input logic j);
    char_pkg::move_state_t ns;
    int   inc, jf, vx, vy, px, py, dx;
    logic hit;
    hit = m_side && (m_state != char_pkg::BOUNCE);
    ns  = char_pkg::IDLE;
    if (hit) ns = char_pkg::BOUNCE;
    else if (m_state inside {char_pkg::IDLE, char_pkg::WALK_LEFT, char_pkg::WALK_RIGHT}) begin
        if (!m_ground) ns = char_pkg::IDLE;
        else if (l) ns = char_pkg::WALK_LEFT;
        else if (r) ns = char_pkg::WALK_RIGHT;
        else if (m_armed) ns = char_pkg::CHARGE;
    end else if (m_state == char_pkg::CHARGE) begin
        ns = (!j || m_charge >= int'(char_pkg::MAX_CHARGE)) ? char_pkg::JUMP : char_pkg::CHARGE;
    end

    inc = (!m_ground && m_state != char_pkg::JUMP) ? int'(char_pkg::GRAVITY) : 0;
    jf  = m_charge * 8;
    vx  = m_vx;
    vy  = m_vy + inc;
    if (m_state == char_pkg::JUMP) begin
        vx = int'(char_pkg::JUMP_VEL_X) + jf / 4 + jf / 8;
        vx = (m_face == 1) ? vx : -vx;
        vy = int'(char_pkg::JUMP_VEL_Y) + jf;
    end else if (m_state == char_pkg::BOUNCE) begin
        vx = m_vx - (m_vx + (m_vx >>> 1) + (m_vx >>> 2));
    end
    vx = limit_vel(vx);
    vy = limit_vel(vy);

    dx = (m_state == char_pkg::WALK_LEFT) ? 3 : (m_state == char_pkg::WALK_RIGHT) ? -3 : 0;
    px = m_px + dx + (vx >>> 9);
    py = m_py + (vy >>> 9);
    if (px < 160) px = 160;
    if (px > 518) px = 518;
    if (py < 20) begin
        py = 20;    // landing
        vx = 0;
        vy = 0;
    end

    if (m_state == char_pkg::CHARGE) m_charge += 10;
    else if (m_state == char_pkg::JUMP) m_charge = 1;
    if (hit) m_face = -m_face;
    else if (m_state == char_pkg::WALK_LEFT) m_face = 1;
    else if (m_state == char_pkg::WALK_RIGHT) m_face = -1;
    if (ns == char_pkg::JUMP) m_armed = 1'b0;

    m_state  = ns;
    m_px     = px;
    m_py     = py;
    m_vx     = vx;
    m_vy     = vy;
    m_ground = (py == 20);
    m_side   = (px <= 160 || px >= 518) && (py > 20);
endtask

task automatic check_all();
    check_phy("pos_x", pos_x, char_pkg::phy_t'(m_px));
    check_phy("pos_y", pos_y, char_pkg::phy_t'(m_py));
    check_phy("vel_x", vel_x, char_pkg::phy_t'(m_vx));
    check_phy("vel_y", vel_y, char_pkg::phy_t'(m_vy));
    check_state("state", state, m_state);
    check_face("face", face, char_pkg::face_t'(m_face));
    check_bit("on_ground", on_ground, m_ground);
endtask

// set the buttons, run one step and compare with the model
task automatic run_step(input logic l, input logic r, input logic j);
    if (j && !jump_btn && m_ground) m_armed = 1'b1;    // press edge arms on the floor
    @(posedge sys_clk);
    left_btn  <= l;
    right_btn <= r;
    jump_btn  <= j;
    do_step();
    model_step(l, r, j);
    check_all();
endtask

// a touchdown at exactly floor height still carries speed into the next step
task automatic fly_until_landed();
    int n;
    n = 0;
    while (!(on_ground && state == char_pkg::IDLE && vel_x == '0 && vel_y == '0)) begin
        run_step(1'b0, 1'b0, 1'b0);
        n++;
        if (n > 200) begin
            $display("character never landed");
            stop_with_fail();
        end
    end
endtask

//------------------------------------------------------------
// directed tests
//------------------------------------------------------------
task automatic test_reset();
    check_all();
    run_step(1'b0, 1'b0, 1'b0);
    check_bit("on_ground after first step", on_ground, 1'b1);
endtask

task automatic test_walk();
    int n, start;
    n     = 3 + ($urandom % 8);
    start = m_px;
    repeat (n) run_step(1'b1, 1'b0, 1'b0);
    run_step(1'b0, 1'b0, 1'b0);
    check_phy("walk left x", pos_x, char_pkg::phy_t'(start + 3 * n));
    check_face("walk left face", face, char_pkg::FACE_LEFT);
    n     = 3 + ($urandom % 8);
    start = m_px;
    repeat (n) run_step(1'b0, 1'b1, 1'b0);
    run_step(1'b0, 1'b0, 1'b0);
    check_phy("walk right x", pos_x, char_pkg::phy_t'(start - 3 * n));
    check_face("walk right face", face, char_pkg::FACE_RIGHT);
endtask

task automatic test_wall_clamp();
    repeat (130) run_step(1'b0, 1'b1, 1'b0);
    check_phy("left clamp x", pos_x, char_pkg::MIN_POS_X);
    repeat (130) run_step(1'b1, 1'b0, 1'b0);
    check_phy("right clamp x", pos_x, char_pkg::MAX_POS_X);
    repeat (40) run_step(1'b0, 1'b1, 1'b0);   // back toward the middle
    run_step(1'b0, 1'b0, 1'b0);
endtask

task automatic test_charge_jump();
    repeat (5) run_step(1'b0, 1'b0, 1'b1);
    check_state("charging", state, char_pkg::CHARGE);
    run_step(1'b0, 1'b0, 1'b0);
    check_state("released", state, char_pkg::JUMP);
    fly_until_landed();
    check_phy("landed y", pos_y, char_pkg::FLOOR_Y);
    check_phy("landed vel_y", vel_y, '0);
endtask

task automatic test_max_charge();
    int n;
    n = 0;
    while (state != char_pkg::JUMP) begin
        run_step(1'b0, 1'b0, 1'b1);
        n++;
        if (n > 60) begin
            $display("full charge never forced a jump");
            stop_with_fail();
        end
    end
    fly_until_landed();
endtask

task automatic test_bounce();
    char_pkg::phy_t v;
    char_pkg::face_t f;
    int n;
    repeat (130) run_step(1'b1, 1'b0, 1'b0);
    run_step(1'b0, 1'b0, 1'b0);
    repeat (4) run_step(1'b0, 1'b0, 1'b1);
    run_step(1'b0, 1'b0, 1'b0);
    n = 0;
    f = char_pkg::face_t'(m_face);
    while (state != char_pkg::BOUNCE) begin
        f = char_pkg::face_t'(m_face);
        run_step(1'b0, 1'b0, 1'b0);
        n++;
        if (n > 40) begin
            $display("character never bounced off the wall");
            stop_with_fail();
        end
    end
    check_face("bounce face", face, -f);
    v = char_pkg::phy_t'(m_vx);
    run_step(1'b0, 1'b0, 1'b0);
    check_phy("bounce vel_x", vel_x, -((v >>> 1) + (v >>> 2)));   // about -3/4 of the speed
    fly_until_landed();
endtask

`endif

/* dv/char_tb.sv */
// testbench top for the player character
// clock, reset, DUT, typed compare tasks and the step strobe driver
`timescale 1ns/1ps

module char_tb;

    logic                  sys_clk;
    logic                  sys_rst_n;
    logic                  step;
    logic                  left_btn;
    logic                  right_btn;
    logic                  jump_btn;
    char_pkg::phy_t        pos_x;
    char_pkg::phy_t        pos_y;
    char_pkg::phy_t        vel_x;
    char_pkg::phy_t        vel_y;
    char_pkg::move_state_t state;
    char_pkg::face_t       face;
    logic                  on_ground;

    char_top #(
        .INIT_POS_X (328),
        .INIT_POS_Y (20)
    ) char_top_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .step      (step),
        .left_btn  (left_btn),
        .right_btn (right_btn),
        .jump_btn  (jump_btn),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .vel_x     (vel_x),
        .vel_y     (vel_y),
        .state     (state),
        .face      (face),
        .on_ground (on_ground)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;    // 8 ns period
    end

    //------------------------------------------------------------
    // failure reporting and compare tasks
    //------------------------------------------------------------
    task automatic stop_with_fail();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_phy(input string what, input char_pkg::phy_t got,
                             input char_pkg::phy_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_with_fail();
        end
    endtask

    task automatic check_state(input string what, input char_pkg::move_state_t got,
                               input char_pkg::move_state_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_with_fail();
        end
    endtask

    task automatic check_face(input string what, input char_pkg::face_t got,
                              input char_pkg::face_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_with_fail();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_with_fail();
        end
    endtask

    // one game step of 6 cycles
    task automatic do_step();
        int waited;
        waited = 0;
        @(posedge sys_clk);
        step <= 1'b1;
        @(posedge sys_clk);
        step <= 1'b0;
        while (!char_top_i.step_d) begin
            @(posedge sys_clk);
            waited++;
            if (waited > 4) begin
                $display("step strobe never reached the FSM");
                stop_with_fail();
            end
        end
        repeat (5 - waited) @(posedge sys_clk);
    endtask

    `include "char_tests.svh"

    initial begin
        void'($urandom(98));
        sys_rst_n <= 1'b0;
        step      <= 1'b0;
        left_btn  <= 1'b0;
        right_btn <= 1'b0;
        jump_btn  <= 1'b0;
        repeat (4) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        @(posedge sys_clk);

        test_reset();
        test_walk();
        test_wall_clamp();
        test_charge_jump();
        test_max_charge();
        test_bounce();

        $display("** PASS **");
        $finish;
    end

endmodule

/* char_top.f */
+incdir+dv
source/char_pkg.sv
source/input_sync.sv
source/move_fsm.sv
source/motion_integrator.sv
source/contact_detect.sv
source/char_top.sv
dv/char_chk.sv
dv/char_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the character testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f char_top.f --top-module char_tb -o char_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out="$(./obj_dir/char_sim 2>&1)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
fi

if grep -qF "** PASS **" <<< "$out"; then
    exit 0
fi
exit 1
